// File: regex_config.svh
// regex coprocessor configuration
// widths, ring size and channel depth shared by every block
`ifndef REGEX_CONFIG_SVH
`define REGEX_CONFIG_SVH

// program counter, also the instruction word address
`define REGEX_PC_WIDTH 8
// one character of the input string
`define REGEX_CHAR_WIDTH 8
// shared memory word, two characters per word
`define REGEX_MEM_WIDTH 16
`define REGEX_MEM_ADDR_WIDTH 11
// character pointer, word address plus byte select
`define REGEX_PTR_WIDTH 12

// basic blocks in the ring
`define REGEX_BB_N 4
// thread entries per channel, a power of two
`define REGEX_CHANNEL_DEPTH 8
// end of string
`define REGEX_TERMINATOR 8'h00

`endif

// File: regex_pkg.sv
// regex coprocessor types
// FSM states, opcodes, instruction word and thread layout
`include "regex_config.svh"

package regex_pkg;

    // coprocessor control FSM
    typedef enum logic [2:0] {
        IDLE,
        FETCH_1ST_CC,
        FETCH_NEXT_CC,
        NO_FETCH_NEXT_CC,
        EXEC,
        COMPLETE_ACCEPTING,
        COMPLETE_REJECTING,
        ERROR
    } copro_state_e;

    // instruction set
    typedef enum logic [1:0] {
        MATCH  = 2'd0,
        SPLIT  = 2'd1,
        JMP    = 2'd2,
        ACCEPT = 2'd3
    } opcode_e;

    // one memory word of the program
    typedef struct packed {
        opcode_e                       opcode;
        logic [5:0]                    unused;
        // character for MATCH, target pc for SPLIT and JMP
        logic [`REGEX_CHAR_WIDTH-1:0]  operand;
    } instr_t;

    // a thread is current when parity equals even_char
    typedef struct packed {
        logic [`REGEX_PC_WIDTH-1:0] pc;
        logic                       parity;
    } thread_t;

endpackage

// File: regex_mem_arbiter.sv
// round-robin arbiter for the single memory port
// grants one requester per cycle, priority rotates past the last grant
`timescale 1ns/1ps
`include "regex_config.svh"

module regex_mem_arbiter #(
    parameter int N = `REGEX_BB_N + 1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [N-1:0]                     req_valid,
    input  logic [`REGEX_MEM_ADDR_WIDTH-1:0] req_addr [N],
    output logic [N-1:0]                     req_ready,
    input  logic                             mem_ready,
    output logic                             mem_valid,
    output logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_addr
);
    localparam int IW = $clog2(N);

    logic [IW-1:0] last;
    logic [IW-1:0] sel;

    // scan from the requester after the last winner
    always_comb
    begin
        int idx;
        sel = last;
        for (int k = N; k >= 1; k--)
        begin
            idx = (int'(last) + k) % N;
            if (req_valid[idx])
            begin
                sel = IW'(idx);
            end
        end
    end

    // address path is purely combinational
    assign mem_valid = |req_valid;
    assign mem_addr  = req_addr[sel];

    always_comb
    begin
        req_ready = '0;
        req_ready[sel] = mem_valid && mem_ready;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            last <= IW'(N - 1);
        end
        else if (mem_valid && mem_ready)
        begin
            last <= sel;
        end
    end

endmodule

// File: regex_channel.sv
// thread channel between two ring stops
// circular FIFO that also tracks how many entries belong to the current character
`timescale 1ns/1ps
`include "regex_config.svh"

module regex_channel #(
    parameter int DEPTH = `REGEX_CHANNEL_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                flip,
    input  logic                push_valid,
    input  regex_pkg::thread_t  push_thread,
    output logic                push_ready,
    input  logic                pop_ready,
    output logic                pop_valid,
    output regex_pkg::thread_t  pop_thread,
    input  logic                even_char,
    input  logic                upstream_waiting,
    output logic                has_current,
    output logic                stuck
);
    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    regex_pkg::thread_t mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] cur_count;
    logic [CW-1:0] count_next;
    logic [CW-1:0] cur_next;
    logic          push;
    logic          pop;

    assign push_ready = (count != CW'(DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_thread = mem[rd_ptr];
    assign push       = push_valid && push_ready;
    assign pop        = pop_valid && pop_ready;

    // occupancy and current-parity count after this cycle's push and pop
    assign count_next = count + CW'(push) - CW'(pop);
    assign cur_next   = cur_count + CW'(push && (push_thread.parity == even_char))
                        - CW'(pop && (pop_thread.parity == even_char));

    assign has_current = (cur_count != '0);
    // upstream block holds a thread it cannot hand over
    assign stuck       = !push_ready && upstream_waiting;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_thread;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            cur_count <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // on a parity flip the next-character entries become the current ones
            cur_count <= flip ? (count_next - cur_next) : cur_next;
        end
    end

endmodule

// File: regex_basic_block.sv
// regex basic block, one stop of the thread ring
// forwards next-character threads, fetches and executes current ones
// and emits the successor threads downstream
`timescale 1ns/1ps
`include "regex_config.svh"

module regex_basic_block (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             flush,
    input  logic                             go,
    input  logic [`REGEX_CHAR_WIDTH-1:0]     cur_char,
    input  logic                             even_char,
    input  logic                             in_valid,
    input  regex_pkg::thread_t               in_thread,
    output logic                             in_ready,
    output logic                             out_valid,
    output regex_pkg::thread_t               out_thread,
    input  logic                             out_ready,
    output logic                             mem_req_valid,
    output logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_req_addr,
    input  logic                             mem_req_ready,
    input  logic [`REGEX_MEM_WIDTH-1:0]      mem_data,
    output logic                             busy,
    output logic                             accepts
);
    typedef enum logic [2:0] {
        BB_IDLE,
        BB_FORWARD,
        BB_FETCH,
        BB_WAIT,
        BB_EXEC,
        BB_PUSH2
    } bb_state_e;

    bb_state_e          state;
    regex_pkg::thread_t thr;
    regex_pkg::instr_t  instr;

    assign in_ready = go && (state == BB_IDLE);
    assign busy     = (state != BB_IDLE);
    // pc is the word address of the instruction
    assign mem_req_addr = {{(`REGEX_MEM_ADDR_WIDTH - `REGEX_PC_WIDTH){1'b0}}, thr.pc};
    assign mem_req_valid = (state == BB_FETCH);

    always_comb
    begin
        out_valid  = 1'b0;
        out_thread = thr;
        accepts    = 1'b0;
        case (state)
            BB_FORWARD: out_valid = 1'b1;
            BB_EXEC:
            begin
                case (instr.opcode)
                    regex_pkg::MATCH:
                    begin
                        // hit moves the thread on to the next character
                        out_valid         = (cur_char == instr.operand);
                        out_thread.pc     = thr.pc + 1'b1;
                        out_thread.parity = ~even_char;
                    end
                    regex_pkg::SPLIT:
                    begin
                        // fall-through branch first, target in BB_PUSH2
                        out_valid     = 1'b1;
                        out_thread.pc = thr.pc + 1'b1;
                    end
                    regex_pkg::JMP:
                    begin
                        out_valid     = 1'b1;
                        out_thread.pc = instr.operand;
                    end
                    default: accepts = 1'b1;
                endcase
            end
            BB_PUSH2:
            begin
                out_valid     = 1'b1;
                out_thread.pc = instr.operand;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            state <= BB_IDLE;
        end
        else
        begin
            case (state)
                BB_IDLE:
                begin
                    if (in_valid && in_ready)
                    begin
                        state <= (in_thread.parity == even_char) ? BB_FETCH : BB_FORWARD;
                    end
                end
                BB_FORWARD: if (out_ready) state <= BB_IDLE;
                BB_FETCH:   if (mem_req_ready) state <= BB_WAIT;
                // granted last cycle so mem_data is ours now
                BB_WAIT:    state <= BB_EXEC;
                BB_EXEC:
                begin
                    if (instr.opcode == regex_pkg::SPLIT)
                    begin
                        if (out_ready) state <= BB_PUSH2;
                    end
                    else if (!out_valid || out_ready)
                    begin
                        state <= BB_IDLE;
                    end
                end
                BB_PUSH2:   if (out_ready) state <= BB_IDLE;
                default:    state <= BB_IDLE;
            endcase
        end
    end

    // thread and instruction payload
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            thr <= in_thread;
        end
        if (state == BB_WAIT)
        begin
            instr <= regex_pkg::instr_t'(mem_data);
        end
    end

endmodule

// File: regex_control_fsm.sv
// regex coprocessor control FSM
// fetches characters, injects the start thread, flips parity between
// characters and reports accept, reject or error
`timescale 1ns/1ps
`include "regex_config.svh"

module regex_control_fsm (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start_ready,
    input  logic [`REGEX_PTR_WIDTH-1:0]      start_ptr,
    output logic                             start_valid,
    output logic                             finish,
    output logic                             accept,
    output logic                             error,
    output logic                             req_valid,
    output logic [`REGEX_MEM_ADDR_WIDTH-1:0] req_addr,
    input  logic                             req_ready,
    input  logic [`REGEX_MEM_WIDTH-1:0]      mem_data,
    input  logic                             running,
    input  logic                             any_accepts,
    input  logic                             all_stuck,
    output logic                             inject_valid,
    output regex_pkg::thread_t               inject_thread,
    input  logic                             inject_ready,
    output logic [`REGEX_CHAR_WIDTH-1:0]     cur_char,
    output logic                             even_char,
    output logic                             go,
    output logic                             flip,
    output logic                             flush
);
    regex_pkg::copro_state_e        state;
    regex_pkg::copro_state_e        state_next;
    logic [`REGEX_PTR_WIDTH-1:0]    ptr;
    logic [`REGEX_PTR_WIDTH-1:0]    ptr_inc;
    logic [`REGEX_MEM_WIDTH-1:0]    word;

    assign ptr_inc  = ptr + 1'b1;
    // low byte holds the even character of a word
    assign cur_char = word[ptr[0]*`REGEX_CHAR_WIDTH +: `REGEX_CHAR_WIDTH];
    assign inject_thread.pc     = '0;
    assign inject_thread.parity = even_char;

    always_comb
    begin
        state_next   = state;
        start_valid  = 1'b0;
        finish       = 1'b0;
        accept       = 1'b0;
        error        = 1'b0;
        req_valid    = 1'b0;
        req_addr     = ptr_inc[`REGEX_PTR_WIDTH-1:1];
        inject_valid = 1'b0;
        go           = 1'b0;
        flip         = 1'b0;
        flush        = 1'b0;
        case (state)
            regex_pkg::IDLE:
            begin
                // no memory traffic until a string is offered
                req_valid = start_ready;
                req_addr  = start_ptr[`REGEX_PTR_WIDTH-1:1];
                if (start_ready && req_ready)
                begin
                    start_valid = 1'b1;
                    state_next  = regex_pkg::FETCH_1ST_CC;
                end
            end
            regex_pkg::FETCH_1ST_CC:
            begin
                inject_valid = 1'b1;
                if (inject_ready) state_next = regex_pkg::EXEC;
            end
            regex_pkg::FETCH_NEXT_CC:
            begin
                state_next = running ? regex_pkg::EXEC : regex_pkg::COMPLETE_REJECTING;
            end
            regex_pkg::NO_FETCH_NEXT_CC:
            begin
                // character already in the latched word
                go         = 1'b1;
                state_next = running ? regex_pkg::EXEC : regex_pkg::COMPLETE_REJECTING;
            end
            regex_pkg::EXEC:
            begin
                go = 1'b1;
                if (any_accepts)
                begin
                    state_next = regex_pkg::COMPLETE_ACCEPTING;
                end
                else if (all_stuck)
                begin
                    // ring jammed, nobody can move a thread
                    state_next = regex_pkg::ERROR;
                end
                else if (!running && cur_char == `REGEX_TERMINATOR)
                begin
                    state_next = regex_pkg::COMPLETE_REJECTING;
                end
                else if (!running && ptr[0])
                begin
                    // next character sits in the following word
                    req_valid = 1'b1;
                    if (req_ready)
                    begin
                        flip       = 1'b1;
                        state_next = regex_pkg::FETCH_NEXT_CC;
                    end
                end
                else if (!running)
                begin
                    flip       = 1'b1;
                    state_next = regex_pkg::NO_FETCH_NEXT_CC;
                end
            end
            regex_pkg::COMPLETE_ACCEPTING:
            begin
                finish     = 1'b1;
                accept     = 1'b1;
                flush      = 1'b1;
                state_next = regex_pkg::IDLE;
            end
            regex_pkg::COMPLETE_REJECTING:
            begin
                finish     = 1'b1;
                flush      = 1'b1;
                state_next = regex_pkg::IDLE;
            end
            default: error = 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= regex_pkg::IDLE;
            ptr       <= '0;
            even_char <= 1'b1;
        end
        else
        begin
            state <= state_next;
            if (start_valid)
            begin
                ptr <= start_ptr;
            end
            else if (flip)
            begin
                ptr       <= ptr_inc;
                even_char <= ~even_char;
            end
        end
    end

    // word granted in the previous cycle arrives now
    always_ff @(posedge clk)
    begin
        if (state == regex_pkg::FETCH_1ST_CC || state == regex_pkg::FETCH_NEXT_CC)
        begin
            word <= mem_data;
        end
    end

endmodule

// File: regex_coprocessor.sv
// regex coprocessor top level
// ring of channels and basic blocks, memory arbiter and control FSM
`timescale 1ns/1ps
`include "regex_config.svh"

module regex_coprocessor (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start_ready,
    input  logic [`REGEX_PTR_WIDTH-1:0]      start_ptr,
    output logic                             start_valid,
    output logic                             finish,
    output logic                             accept,
    output logic                             error,
    input  logic                             mem_ready,
    output logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_addr,
    input  logic [`REGEX_MEM_WIDTH-1:0]      mem_data,
    output logic                             mem_valid
);
    localparam int N = `REGEX_BB_N;

    // requesters 0..N-1 are blocks, N is the FSM
    logic [N:0]                      req_valid;
    logic [N:0]                      req_ready;
    logic [`REGEX_MEM_ADDR_WIDTH-1:0] req_addr [N+1];

    logic [N-1:0] push_valid, push_ready, pop_valid, pop_ready;
    logic [N-1:0] out_valid, out_ready;
    logic [N-1:0] bb_busy, bb_accepts, ch_has_current, ch_stuck;
    regex_pkg::thread_t push_thread [N];
    regex_pkg::thread_t pop_thread [N];
    regex_pkg::thread_t out_thread [N];

    logic                            inject_valid;
    logic                            inject_ready;
    regex_pkg::thread_t              inject_thread;
    logic [`REGEX_CHAR_WIDTH-1:0]    cur_char;
    logic                            even_char, go, flip, flush;
    logic                            running, any_accepts, all_stuck;

    assign running     = (|bb_busy) || (|ch_has_current);
    assign any_accepts = |bb_accepts;
    assign all_stuck   = &ch_stuck;

    // channel 0 takes the start thread ahead of the last block
    assign push_valid[0]    = inject_valid ? 1'b1 : out_valid[N-1];
    assign push_thread[0]   = inject_valid ? inject_thread : out_thread[N-1];
    assign out_ready[N-1]   = !inject_valid && push_ready[0];
    assign inject_ready     = push_ready[0];

    for (genvar i = 0; i < N; i++)
    begin : g_ring
        if (i > 0)
        begin : g_link
            assign push_valid[i]  = out_valid[i-1];
            assign push_thread[i] = out_thread[i-1];
            assign out_ready[i-1] = push_ready[i];
        end

        regex_channel u_channel (
            .clk(clk), .rst(rst), .flush(flush), .flip(flip),
            .push_valid(push_valid[i]), .push_thread(push_thread[i]),
            .push_ready(push_ready[i]), .pop_ready(pop_ready[i]),
            .pop_valid(pop_valid[i]), .pop_thread(pop_thread[i]),
            .even_char(even_char), .upstream_waiting(out_valid[(i+N-1)%N]),
            .has_current(ch_has_current[i]), .stuck(ch_stuck[i])
        );

        regex_basic_block u_bb (
            .clk(clk), .rst(rst), .flush(flush), .go(go),
            .cur_char(cur_char), .even_char(even_char),
            .in_valid(pop_valid[i]), .in_thread(pop_thread[i]), .in_ready(pop_ready[i]),
            .out_valid(out_valid[i]), .out_thread(out_thread[i]), .out_ready(out_ready[i]),
            .mem_req_valid(req_valid[i]), .mem_req_addr(req_addr[i]),
            .mem_req_ready(req_ready[i]), .mem_data(mem_data),
            .busy(bb_busy[i]), .accepts(bb_accepts[i])
        );
    end

    regex_control_fsm u_fsm (
        .clk(clk), .rst(rst),
        .start_ready(start_ready), .start_ptr(start_ptr), .start_valid(start_valid),
        .finish(finish), .accept(accept), .error(error),
        .req_valid(req_valid[N]), .req_addr(req_addr[N]), .req_ready(req_ready[N]),
        .mem_data(mem_data),
        .running(running), .any_accepts(any_accepts), .all_stuck(all_stuck),
        .inject_valid(inject_valid), .inject_thread(inject_thread),
        .inject_ready(inject_ready),
        .cur_char(cur_char), .even_char(even_char), .go(go), .flip(flip), .flush(flush)
    );

    regex_mem_arbiter #(.N(N + 1)) u_arbiter (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_addr(req_addr), .req_ready(req_ready),
        .mem_ready(mem_ready), .mem_valid(mem_valid), .mem_addr(mem_addr)
    );

endmodule

// File: regex_checker.sv
// regex coprocessor outcome checker
// concurrent assertions on start, finish, accept and error
`timescale 1ns/1ps

module regex_checker (
    input logic clk,
    input logic rst,
    input logic start_ready,
    input logic start_valid,
    input logic finish,
    input logic accept,
    input logic error
);
    // accept only rides on the finish pulse
    a_accept_finish: assert property (@(posedge clk) disable iff (rst) accept |-> finish)
        else $error("accept high without finish");

    // finish is a single-cycle pulse
    a_finish_pulse: assert property (@(posedge clk) disable iff (rst) finish |=> !finish)
        else $error("finish held for two cycles");

    // a jammed ring stays in error until reset
    a_error_sticky: assert property (@(posedge clk) disable iff (rst) error |=> error)
        else $error("error dropped without reset");

    a_start_ready: assert property (@(posedge clk) disable iff (rst) start_valid |-> start_ready)
        else $error("start_valid without start_ready");

endmodule

bind regex_coprocessor regex_checker u_checker (
    .clk(clk), .rst(rst), .start_ready(start_ready), .start_valid(start_valid),
    .finish(finish), .accept(accept), .error(error)
);

// File: regex_tb.sv
// regex coprocessor testbench
// memory model with random ready, program and string loader,
// thread-set reference model and a compare process on finish
`timescale 1ns/1ps
`include "regex_config.svh"

module regex_tb;
    localparam int STR_WORD     = 512;
    localparam int START_PTR    = 2 * STR_WORD;
    localparam int RANDOM_RUNS  = 20;
    // 36 runs of at most a few hundred cycles each plus the jam test
    localparam int MAX_CYCLES   = 20000;
    localparam int JAM_LIMIT    = 4000;
    localparam int STEP_LIMIT   = 10000;
    localparam int PROG_LITERAL = 0;
    localparam int PROG_ALT     = 1;
    localparam int PROG_STAR    = 2;
    localparam int PROG_SINGLE  = 3;
    localparam int PROG_ACCEPT  = 4;
    localparam int PROG_CHAIN   = 5;

    logic                             clk;
    logic                             rst;
    logic                             start_ready;
    logic [`REGEX_PTR_WIDTH-1:0]      start_ptr;
    logic                             start_valid;
    logic                             finish;
    logic                             accept;
    logic                             error;
    logic                             mem_ready;
    logic [`REGEX_MEM_ADDR_WIDTH-1:0] mem_addr;
    logic [`REGEX_MEM_WIDTH-1:0]      mem_data;
    logic                             mem_valid;

    logic [`REGEX_MEM_WIDTH-1:0] mem [2048];
    integer      seed;
    int          errors;
    int          checks;
    int          cycles;
    bit          expected [$];
    bit          exp_accept;
    logic [7:0]  rnd_chars [RANDOM_RUNS][8];
    int          rnd_len [RANDOM_RUNS];

    regex_coprocessor UUT (
        .clk(clk), .rst(rst),
        .start_ready(start_ready), .start_ptr(start_ptr), .start_valid(start_valid),
        .finish(finish), .accept(accept), .error(error),
        .mem_ready(mem_ready), .mem_addr(mem_addr), .mem_data(mem_data),
        .mem_valid(mem_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // word comes back one cycle after the transfer
    always @(posedge clk)
    begin
        if (mem_valid && mem_ready)
        begin
            mem_data <= mem[mem_addr];
        end
        // ready about three cycles in four
        mem_ready <= (({$random(seed)} % 4) != 0);
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the test did not end within %0d cycles", MAX_CYCLES);
            $display("errors: %0d, accept checks: %0d", errors, checks);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // each finish pulse retires the oldest pending run
    always @(posedge clk)
    begin
        if (!rst && finish)
        begin
            if (expected.size() == 0)
            begin
                $display("ERROR %0t: finish with no run pending", $time);
                errors++;
            end
            else
            begin
                exp_accept = expected.pop_front();
                checks++;
                if (accept !== exp_accept)
                begin
                    $display("ERROR %0t: accept %0b, expected %0b", $time, accept, exp_accept);
                    errors++;
                end
            end
        end
    end

    // thread sets per character with closure through SPLIT and JMP and no dedup
    function automatic bit expect_accept(input int ptr);
        int          cur [$];
        int          nxt [$];
        int          pc;
        int          steps;
        logic [15:0] w;
        logic [7:0]  ch;
        steps = 0;
        cur.push_back(0);
        for (int p = ptr; p < ptr + 2048; p++)
        begin
            w  = mem[p / 2];
            ch = (p % 2 == 1) ? w[15:8] : w[7:0];
            nxt.delete();
            while (cur.size() > 0)
            begin
                pc = cur.pop_front();
                w  = mem[pc];
                steps++;
                if (steps > STEP_LIMIT)
                begin
                    return 1'b0;
                end
                case (regex_pkg::opcode_e'(w[15:14]))
                    regex_pkg::MATCH:
                    begin
                        if (w[7:0] == ch)
                        begin
                            nxt.push_back(pc + 1);
                        end
                    end
                    regex_pkg::SPLIT:
                    begin
                        cur.push_back(pc + 1);
                        cur.push_back(int'(w[7:0]));
                    end
                    regex_pkg::JMP: cur.push_back(int'(w[7:0]));
                    regex_pkg::ACCEPT: return 1'b1;
                endcase
            end
            if (ch == `REGEX_TERMINATOR || nxt.size() == 0)
            begin
                return 1'b0;
            end
            cur = nxt;
        end
        return 1'b0;
    endfunction

    task automatic put_instr(input int pc, input regex_pkg::opcode_e op, input logic [7:0] arg);
        mem[pc] = {op, 6'd0, arg};
    endtask

    task automatic load_program(input int which);
        case (which)
            PROG_LITERAL:
            begin
                put_instr(0, regex_pkg::MATCH, "a");
                put_instr(1, regex_pkg::MATCH, "b");
                put_instr(2, regex_pkg::MATCH, "c");
                put_instr(3, regex_pkg::ACCEPT, 8'd0);
            end
            PROG_ALT:
            begin
                // ab|cd
                put_instr(0, regex_pkg::SPLIT, 8'd4);
                put_instr(1, regex_pkg::MATCH, "a");
                put_instr(2, regex_pkg::MATCH, "b");
                put_instr(3, regex_pkg::JMP, 8'd6);
                put_instr(4, regex_pkg::MATCH, "c");
                put_instr(5, regex_pkg::MATCH, "d");
                put_instr(6, regex_pkg::ACCEPT, 8'd0);
            end
            PROG_STAR:
            begin
                // a*b
                put_instr(0, regex_pkg::SPLIT, 8'd3);
                put_instr(1, regex_pkg::MATCH, "a");
                put_instr(2, regex_pkg::JMP, 8'd0);
                put_instr(3, regex_pkg::MATCH, "b");
                put_instr(4, regex_pkg::ACCEPT, 8'd0);
            end
            PROG_SINGLE:
            begin
                put_instr(0, regex_pkg::MATCH, "a");
                put_instr(1, regex_pkg::ACCEPT, 8'd0);
            end
            PROG_ACCEPT: put_instr(0, regex_pkg::ACCEPT, 8'd0);
            default:
            begin
                // ten doublings and a jump back to the top so the thread count only grows
                for (int k = 0; k < 10; k++)
                begin
                    put_instr(k, regex_pkg::SPLIT, 8'(k + 1));
                end
                put_instr(10, regex_pkg::JMP, 8'd0);
            end
        endcase
    endtask

    // even characters in the low byte of a word
    task automatic put_char(input int idx, input logic [7:0] ch);
        if (idx % 2 == 1)
        begin
            mem[STR_WORD + idx / 2][15:8] = ch;
        end
        else
        begin
            mem[STR_WORD + idx / 2][7:0] = ch;
        end
    endtask

    task automatic load_string(input string s);
        for (int i = 0; i < s.len(); i++)
        begin
            put_char(i, s[i]);
        end
        put_char(s.len(), `REGEX_TERMINATOR);
    endtask

    task automatic wait_start();
        start_ready <= 1'b1;
        do
        begin
            @(posedge clk);
        end
        while (!start_valid);
        start_ready <= 1'b0;
    endtask

    task automatic run_loaded();
        expected.push_back(expect_accept(START_PTR));
        wait_start();
        do
        begin
            @(posedge clk);
        end
        while (!finish);
        // let the complete cycle pass before memory is rewritten
        @(posedge clk);
    endtask

    task automatic run_string(input string s, input bit known);
        load_string(s);
        if (expect_accept(START_PTR) != known)
        begin
            $display("reference model disagrees with the known outcome for \"%s\"", s);
            errors++;
        end
        run_loaded();
    endtask

    task automatic check_quiet();
        if (finish || accept || error || start_valid || mem_valid)
        begin
            $display("ERROR %0t: outputs active after reset", $time);
            errors++;
        end
    endtask

    initial
    begin
        int wait_cnt;
        seed        = 37908;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        rst         = 1'b1;
        start_ready = 1'b0;
        start_ptr   = `REGEX_PTR_WIDTH'(START_PTR);
        mem_ready   = 1'b0;
        mem_data    = '0;
        for (int a = 0; a < 2048; a++)
        begin
            mem[a] = 16'(a * 40503);
        end
        // random strings are drawn before the first clock edge
        for (int r = 0; r < RANDOM_RUNS; r++)
        begin
            rnd_len[r] = {$random(seed)} % 8;
            for (int i = 0; i < 8; i++)
            begin
                rnd_chars[r][i] = 8'h61 + 8'({$random(seed)} % 3);
            end
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_quiet();

        // anchored literal
        load_program(PROG_LITERAL);
        run_string("abcd", 1'b1);
        run_string("abx", 1'b0);
        run_string("abc", 1'b1);
        // alternation with both branches in flight
        load_program(PROG_ALT);
        run_string("ab", 1'b1);
        run_string("cd", 1'b1);
        run_string("ce", 1'b0);
        run_string("ad", 1'b0);
        // star loop over odd and even lengths
        load_program(PROG_STAR);
        run_string("b", 1'b1);
        run_string("ab", 1'b1);
        run_string("aab", 1'b1);
        run_string("aaab", 1'b1);
        run_string("aaaa", 1'b0);
        run_string("aaaab", 1'b1);
        run_string("c", 1'b0);
        // empty string
        load_program(PROG_SINGLE);
        run_string("", 1'b0);
        load_program(PROG_ACCEPT);
        run_string("", 1'b1);

        // random strings against the first three programs
        for (int r = 0; r < RANDOM_RUNS; r++)
        begin
            load_program(r % 3);
            for (int i = 0; i < rnd_len[r]; i++)
            begin
                put_char(i, rnd_chars[r][i]);
            end
            put_char(rnd_len[r], `REGEX_TERMINATOR);
            run_loaded();
        end

        // split chain jams the ring while no finish is pending
        load_program(PROG_CHAIN);
        load_string("a");
        wait_start();
        wait_cnt = 0;
        while (!error && wait_cnt < JAM_LIMIT)
        begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!error)
        begin
            $display("the jammed ring did not raise error within %0d cycles", JAM_LIMIT);
            errors++;
        end
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_quiet();

        $display("errors: %0d, accept checks: %0d", errors, checks);
        if (errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
regex_pkg.sv
regex_mem_arbiter.sv
regex_channel.sv
regex_basic_block.sv
regex_control_fsm.sv
regex_coprocessor.sv
regex_checker.sv
regex_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = regex_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
